// File: compile.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_write_stage.sv
verilog/csr_trap_regs.sv
verilog/csr_timer_irq.sv
verilog/csr_save_regs.sv
verilog/csr_read_mux.sv
verilog/csr_top.sv
tb/csr_props.sv
tb/csr_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module csr_tb -f compile.f -o csr_sim

run: build
	@out="$$(./obj_dir/csr_sim)"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation completed successfully$$"

lint:
	verilator --lint-only -Wall +incdir+verilog --top-module csr_top \
		verilog/csr_pkg.sv verilog/csr_write_stage.sv verilog/csr_trap_regs.sv \
		verilog/csr_timer_irq.sv verilog/csr_save_regs.sv verilog/csr_read_mux.sv \
		verilog/csr_top.sv

clean:
	rm -rf obj_dir

// File: tb/csr_tb.sv
`include "csr_defines.svh"

module csr_tb;

    localparam int CLK_PERIOD = 100;
    localparam int QUARTER    = CLK_PERIOD / 4;
    localparam int TIMER_INIT = 5;
    localparam int OP_WRITE   = 0;
    localparam int OP_READ    = 1;
    localparam int OP_EXC     = 2;
    localparam int OP_ERTN    = 3;
    localparam int OP_FLUSH   = 4;
    localparam int OP_WAIT    = 5;
    localparam int OP_HWIRQ   = 6;
    localparam int OP_IRQ     = 7;

    logic clk;
    logic aresetn, wen_in, d_idle, flush;
    logic exception, ertn, tlb_exception, wen_expcode, wen_era, wen_badv;
    logic wen_csr, cpu_interrupt, idle_over;
    csr_pkg::csr_addr_t addr_in;
    csr_pkg::csr_word_t wdata_in, era_in, badv_in;
    csr_pkg::csr_word_t rdata, crmd, estat, era_out, eentry, tid;
    csr_pkg::expcode_t  expcode_in;
    csr_pkg::hw_irq_t   hardware_interrupt;

    int                 op_q[$];
    csr_pkg::csr_addr_t addr_q[$];
    csr_pkg::csr_word_t data_q[$];
    csr_pkg::csr_word_t exp_q[$];
    int                 errors = 0;
    bit                 table_ready = 1'b0;

    csr_top u_dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic csr_pkg::csr_word_t xorshift32(input csr_pkg::csr_word_t x);
        csr_pkg::csr_word_t s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // CRMD image with DATF and DATM both 1
    function automatic csr_pkg::csr_word_t crmd_val(input logic [1:0] plv, input logic ie,
                                                    input logic da, input logic pg);
        return {23'd0, 2'b01, 2'b01, pg, da, ie, plv};
    endfunction

    task automatic add_step(input int op, input csr_pkg::csr_addr_t a,
                            input csr_pkg::csr_word_t d, input csr_pkg::csr_word_t e);
        op_q.push_back(op);
        addr_q.push_back(a);
        data_q.push_back(d);
        exp_q.push_back(e);
    endtask

    task automatic build_table();
        csr_pkg::csr_word_t rng;
        csr_pkg::csr_word_t vals [5];
        csr_pkg::csr_addr_t a;
        int i;
        rng = 32'hbf8416b8;
        add_step(OP_READ, `CSR_CRMD, 0, crmd_val(2'd0, 1'b0, 1'b1, 1'b0));
        for (i = 0; i < 5; i++) begin
            rng = xorshift32(rng);
            vals[i] = rng;
            a = (i < 4) ? csr_pkg::csr_addr_t'(`CSR_SAVE0 + i) : `CSR_TID;
            add_step(OP_WRITE, a, rng, 0);
        end
        for (i = 0; i < 5; i++) begin
            a = (i < 4) ? csr_pkg::csr_addr_t'(`CSR_SAVE0 + i) : `CSR_TID;
            add_step(OP_READ, a, 0, vals[i]);
        end
        // Bit 10 is never enabled
        add_step(OP_WRITE, `CSR_ECFG, 32'hffff_ffff, 0);
        add_step(OP_READ, `CSR_ECFG, 0, 32'h0000_1bff);
        add_step(OP_WRITE, `CSR_EENTRY, 32'h1c00_80ff, 0);
        add_step(OP_READ, `CSR_EENTRY, 0,
                 32'h1c00_80ff & ~((32'd1 << `EENTRY_VA_LSB) - 32'd1));
        add_step(OP_WRITE, `CSR_ERA, 32'h1c00_2468, 0);
        add_step(OP_READ, `CSR_ERA, 0, 32'h1c00_2468);
        // Cancelled write must leave SAVE0 alone
        add_step(OP_FLUSH, `CSR_SAVE0, ~vals[0], 0);
        add_step(OP_READ, `CSR_SAVE0, 0, vals[0]);
        add_step(OP_WRITE, `CSR_CRMD, crmd_val(2'd3, 1'b1, 1'b1, 1'b0), 0);
        add_step(OP_EXC, 14'd0, 32'h08, 0);
        add_step(OP_READ, `CSR_CRMD, 0, crmd_val(2'd0, 1'b0, 1'b1, 1'b0));
        add_step(OP_READ, `CSR_PRMD, 0, 32'h7);
        add_step(OP_READ, `CSR_ESTAT, 0, {10'd0, 6'h08, 16'd0});
        add_step(OP_ERTN, 14'd0, 0, 0);
        add_step(OP_READ, `CSR_CRMD, 0, crmd_val(2'd3, 1'b1, 1'b1, 1'b0));
        add_step(OP_EXC, 14'd1, {26'd0, `ECODE_TLBR}, 0);
        add_step(OP_READ, `CSR_CRMD, 0, crmd_val(2'd0, 1'b0, 1'b1, 1'b0));
        add_step(OP_ERTN, 14'd0, 0, 0);
        add_step(OP_READ, `CSR_CRMD, 0, crmd_val(2'd3, 1'b1, 1'b0, 1'b1));
        // Illegal DA/PG pairs keep the mode bits
        add_step(OP_WRITE, `CSR_CRMD, crmd_val(2'd3, 1'b1, 1'b1, 1'b1), 0);
        add_step(OP_READ, `CSR_CRMD, 0, crmd_val(2'd3, 1'b1, 1'b0, 1'b1));
        add_step(OP_WRITE, `CSR_CRMD, crmd_val(2'd2, 1'b1, 1'b0, 1'b0), 0);
        add_step(OP_READ, `CSR_CRMD, 0, crmd_val(2'd2, 1'b1, 1'b0, 1'b1));
        add_step(OP_WRITE, `CSR_CRMD, crmd_val(2'd0, 1'b1, 1'b1, 1'b0), 0);
        // Timer interrupt
        add_step(OP_WRITE, `CSR_TCFG, (TIMER_INIT << 2) | 1, 0);
        add_step(OP_WAIT, `CSR_ESTAT, 32'd1 << `IRQ_TI_BIT, 32'd1 << `IRQ_TI_BIT);
        add_step(OP_IRQ, 14'd0, 0, 32'd3);
        add_step(OP_WRITE, `CSR_TICLR, 32'd1, 0);
        add_step(OP_READ, `CSR_ESTAT, 0, {10'd0, `ECODE_TLBR, 16'd0});
        add_step(OP_IRQ, 14'd0, 0, 32'd0);
        // Hardware line 0 is ESTAT bit 2
        add_step(OP_WRITE, `CSR_ECFG, 32'h0000_0800, 0);
        add_step(OP_HWIRQ, 14'd0, 32'h1, 0);
        add_step(OP_IRQ, 14'd0, 0, 32'd2);
        add_step(OP_WRITE, `CSR_ECFG, 32'h0000_0004, 0);
        add_step(OP_IRQ, 14'd0, 0, 32'd3);
        add_step(OP_WRITE, `CSR_CRMD, crmd_val(2'd0, 1'b0, 1'b1, 1'b0), 0);
        add_step(OP_IRQ, 14'd0, 0, 32'd2);
        add_step(OP_HWIRQ, 14'd0, 32'h0, 0);
        add_step(OP_IRQ, 14'd0, 0, 32'd0);
    endtask

    task automatic do_write(input csr_pkg::csr_addr_t a, input csr_pkg::csr_word_t d);
        int n;
        n = 0;
        wen_in = 1'b1;
        addr_in = a;
        wdata_in = d;
        d_idle = 1'b1;
        @(negedge clk);
        wen_in = 1'b0;
        while (!wen_csr && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!wen_csr) begin
            $display("Write to CSR %h was never released by the write stage", a);
            errors++;
        end
        // Commit edge, then the register update edge
        repeat (2) @(negedge clk);
    endtask

    task automatic cancel_write(input csr_pkg::csr_addr_t a, input csr_pkg::csr_word_t d);
        wen_in = 1'b1;
        addr_in = a;
        wdata_in = d;
        d_idle = 1'b0;
        @(negedge clk);
        wen_in = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        d_idle = 1'b1;
        repeat (3) begin
            #(QUARTER);
            if (wen_csr !== 1'b0) begin
                $display("MISMATCH at %0t: wen_csr high for a flushed write", $time);
                errors++;
            end
            @(negedge clk);
        end
    endtask

    task automatic check_read(input csr_pkg::csr_addr_t a, input csr_pkg::csr_word_t e);
        csr_pkg::csr_word_t port_val;
        logic has_port;
        addr_in = a;
        #(QUARTER);
        if (rdata !== e) begin
            $display("MISMATCH at %0t: CSR %h read %h, expected %h", $time, a, rdata, e);
            errors++;
        end
        // Registers that also leave the top level on a port of their own
        has_port = 1'b1;
        port_val = '0;
        case (a)
            `CSR_CRMD:   port_val = crmd;
            `CSR_ESTAT:  port_val = estat;
            `CSR_ERA:    port_val = era_out;
            `CSR_EENTRY: port_val = eentry;
            `CSR_TID:    port_val = tid;
            default:     has_port = 1'b0;
        endcase
        if (has_port && port_val !== e) begin
            $display("MISMATCH at %0t: CSR %h output port %h, expected %h",
                     $time, a, port_val, e);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic wait_for_bits(input csr_pkg::csr_addr_t a, input csr_pkg::csr_word_t mask,
                                 input csr_pkg::csr_word_t e);
        int n;
        logic hit;
        n = 0;
        hit = 1'b0;
        addr_in = a;
        while (!hit && n < TIMER_INIT + 6) begin
            #(QUARTER);
            hit = ((rdata & mask) == e);
            @(negedge clk);
            n++;
        end
        if (!hit) begin
            $display("CSR %h bits %h did not reach %h within %0d cycles", a, mask, e, n);
            errors++;
        end
    endtask

    task automatic check_irq(input csr_pkg::csr_word_t e);
        #(QUARTER);
        if ({idle_over, cpu_interrupt} !== e[1:0]) begin
            $display("MISMATCH at %0t: idle_over/cpu_interrupt %b%b, expected %b",
                     $time, idle_over, cpu_interrupt, e[1:0]);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic run_step(input int op, input csr_pkg::csr_addr_t a,
                            input csr_pkg::csr_word_t d, input csr_pkg::csr_word_t e);
        case (op)
            OP_WRITE: do_write(a, d);
            OP_READ:  check_read(a, e);
            OP_FLUSH: cancel_write(a, d);
            OP_WAIT:  wait_for_bits(a, d, e);
            OP_IRQ:   check_irq(e);
            OP_HWIRQ: hardware_interrupt = d[7:0];
            OP_EXC: begin
                exception = 1'b1;
                tlb_exception = a[0];
                expcode_in = d[6:0];
                @(negedge clk);
                exception = 1'b0;
                tlb_exception = 1'b0;
            end
            OP_ERTN: begin
                ertn = 1'b1;
                @(negedge clk);
                ertn = 1'b0;
            end
            default: begin
                $display("Unknown step kind %0d in the stimulus table", op);
                errors++;
            end
        endcase
    endtask

    initial begin
        int step;
        aresetn = 1'b0;
        wen_in = 1'b0;
        addr_in = '0;
        wdata_in = '0;
        d_idle = 1'b0;
        flush = 1'b0;
        exception = 1'b0;
        ertn = 1'b0;
        tlb_exception = 1'b0;
        expcode_in = '0;
        wen_expcode = 1'b0;
        era_in = '0;
        wen_era = 1'b0;
        badv_in = '0;
        wen_badv = 1'b0;
        hardware_interrupt = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;
        @(negedge clk);
        for (step = 0; step < op_q.size(); step++) begin
            run_step(op_q[step], addr_q[step], data_q[step], exp_q[step]);
        end
        $display("Done: %0d check errors, %0d assertion failures",
                 errors, u_dut.u_props.fail_count);
        if (errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #((op_q.size() * 20 + 50) * CLK_PERIOD);
        $display("Watchdog expired before the stimulus table finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: tb/csr_props.sv
module csr_props (
    input logic clk,
    input logic aresetn,
    input logic commit_en,
    input logic wen_csr,
    input logic flush,
    input logic cpu_interrupt,
    input logic crmd_ie
);

    int fail_count = 0;

    // Commit strobe lasts one cycle
    commit_single: assert property (@(posedge clk) disable iff (!aresetn)
        commit_en |=> !commit_en)
        else begin
            fail_count++;
            $error("commit_en high for two cycles in a row");
        end

    release_then_commit: assert property (@(posedge clk) disable iff (!aresetn)
        (wen_csr && !flush) |=> commit_en)
        else begin
            fail_count++;
            $error("wen_csr was not followed by commit_en");
        end

    irq_needs_ie: assert property (@(posedge clk) disable iff (!aresetn)
        cpu_interrupt |-> crmd_ie)
        else begin
            fail_count++;
            $error("cpu_interrupt high while CRMD.IE is clear");
        end

endmodule

bind csr_top csr_props u_props (
    .clk(clk),
    .aresetn(aresetn),
    .commit_en(commit_en),
    .wen_csr(wen_csr),
    .flush(flush),
    .cpu_interrupt(cpu_interrupt),
    .crmd_ie(crmd_ie)
);

// File: verilog/csr_top.sv
`include "csr_defines.svh"

module csr_top (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               wen_in,
    input  csr_pkg::csr_addr_t addr_in,
    input  csr_pkg::csr_word_t wdata_in,
    input  logic               d_idle,
    input  logic               flush,
    input  logic               exception,
    input  logic               ertn,
    input  logic               tlb_exception,
    input  csr_pkg::expcode_t  expcode_in,
    input  logic               wen_expcode,
    input  csr_pkg::csr_word_t era_in,
    input  logic               wen_era,
    input  csr_pkg::csr_word_t badv_in,
    input  logic               wen_badv,
    input  csr_pkg::hw_irq_t   hardware_interrupt,
    output csr_pkg::csr_word_t rdata,
    output logic               wen_csr,
    output csr_pkg::csr_word_t crmd,
    output csr_pkg::csr_word_t estat,
    output csr_pkg::csr_word_t era_out,
    output csr_pkg::csr_word_t eentry,
    output csr_pkg::csr_word_t tid,
    output logic               cpu_interrupt,
    output logic               idle_over
);

    logic               commit_en;
    csr_pkg::csr_addr_t commit_addr;
    csr_pkg::csr_word_t commit_data;
    csr_pkg::csr_word_t prmd;
    csr_pkg::csr_word_t badv;
    csr_pkg::ecode_t    ecode;
    logic               esubcode;
    logic               crmd_ie;
    csr_pkg::csr_word_t ecfg;
    csr_pkg::irq_vec_t  estat_is;
    csr_pkg::csr_word_t tcfg;
    csr_pkg::csr_word_t tval;
    csr_pkg::csr_word_t save0;
    csr_pkg::csr_word_t save1;
    csr_pkg::csr_word_t save2;
    csr_pkg::csr_word_t save3;

    csr_write_stage u_write_stage (
        .clk(clk), .aresetn(aresetn), .wen_in(wen_in), .addr_in(addr_in),
        .wdata_in(wdata_in), .d_idle(d_idle), .flush(flush), .wen_csr(wen_csr),
        .commit_en(commit_en), .commit_addr(commit_addr), .commit_data(commit_data)
    );

    csr_trap_regs u_trap_regs (
        .clk(clk), .aresetn(aresetn), .commit_en(commit_en),
        .commit_addr(commit_addr), .commit_data(commit_data),
        .exception(exception), .ertn(ertn), .tlb_exception(tlb_exception),
        .expcode_in(expcode_in), .wen_expcode(wen_expcode),
        .era_in(era_in), .wen_era(wen_era), .badv_in(badv_in), .wen_badv(wen_badv),
        .crmd(crmd), .prmd(prmd), .ecode(ecode), .esubcode(esubcode),
        .era(era_out), .badv(badv), .eentry(eentry), .crmd_ie(crmd_ie)
    );

    csr_timer_irq u_timer_irq (
        .clk(clk), .aresetn(aresetn), .commit_en(commit_en),
        .commit_addr(commit_addr), .commit_data(commit_data),
        .hardware_interrupt(hardware_interrupt), .crmd_ie(crmd_ie),
        .ecfg(ecfg), .estat_is(estat_is), .tcfg(tcfg), .tval(tval),
        .cpu_interrupt(cpu_interrupt), .idle_over(idle_over)
    );

    csr_save_regs u_save_regs (
        .clk(clk), .aresetn(aresetn), .commit_en(commit_en),
        .commit_addr(commit_addr), .commit_data(commit_data),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3), .tid(tid)
    );

    csr_read_mux u_read_mux (
        .addr_in(addr_in), .crmd(crmd), .prmd(prmd), .ecfg(ecfg),
        .era(era_out), .badv(badv), .eentry(eentry),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .tid(tid), .tcfg(tcfg), .tval(tval), .estat_is(estat_is),
        .ecode(ecode), .esubcode(esubcode), .rdata(rdata), .estat(estat)
    );

endmodule

// File: verilog/csr_read_mux.sv
`include "csr_defines.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_t addr_in,
    input  csr_pkg::csr_word_t crmd,
    input  csr_pkg::csr_word_t prmd,
    input  csr_pkg::csr_word_t ecfg,
    input  csr_pkg::csr_word_t era,
    input  csr_pkg::csr_word_t badv,
    input  csr_pkg::csr_word_t eentry,
    input  csr_pkg::csr_word_t save0,
    input  csr_pkg::csr_word_t save1,
    input  csr_pkg::csr_word_t save2,
    input  csr_pkg::csr_word_t save3,
    input  csr_pkg::csr_word_t tid,
    input  csr_pkg::csr_word_t tcfg,
    input  csr_pkg::csr_word_t tval,
    input  csr_pkg::irq_vec_t  estat_is,
    input  csr_pkg::ecode_t    ecode,
    input  logic               esubcode,
    output csr_pkg::csr_word_t rdata,
    output csr_pkg::csr_word_t estat
);

    always_comb begin
        estat                  = '0;
        estat[`ESTAT_IS]       = estat_is;
        estat[`ESTAT_ECODE]    = ecode;
        estat[`ESTAT_ESUBCODE] = esubcode;
    end

    always_comb begin
        case (addr_in)
            `CSR_CRMD:   rdata = crmd;
            `CSR_PRMD:   rdata = prmd;
            `CSR_ECFG:   rdata = ecfg;
            `CSR_ESTAT:  rdata = estat;
            `CSR_ERA:    rdata = era;
            `CSR_BADV:   rdata = badv;
            `CSR_EENTRY: rdata = eentry;
            `CSR_SAVE0:  rdata = save0;
            `CSR_SAVE1:  rdata = save1;
            `CSR_SAVE2:  rdata = save2;
            `CSR_SAVE3:  rdata = save3;
            `CSR_TID:    rdata = tid;
            `CSR_TCFG:   rdata = tcfg;
            `CSR_TVAL:   rdata = tval;
            // Write-only clear register
            `CSR_TICLR:  rdata = '0;
            default:     rdata = '0;
        endcase
    end

endmodule

// File: verilog/csr_save_regs.sv
`include "csr_defines.svh"

module csr_save_regs (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               commit_en,
    input  csr_pkg::csr_addr_t commit_addr,
    input  csr_pkg::csr_word_t commit_data,
    output csr_pkg::csr_word_t save0,
    output csr_pkg::csr_word_t save1,
    output csr_pkg::csr_word_t save2,
    output csr_pkg::csr_word_t save3,
    output csr_pkg::csr_word_t tid
);

    csr_pkg::csr_word_t save_q [4];
    csr_pkg::csr_word_t tid_q;

    // Scratch registers sit at consecutive numbers
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (commit_en && commit_addr == csr_pkg::csr_addr_t'(`CSR_SAVE0 + i)) begin
                save_q[i] <= commit_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tid_q <= '0;
        end else if (commit_en && commit_addr == `CSR_TID) begin
            tid_q <= commit_data;
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];
    assign tid   = tid_q;

endmodule

// File: verilog/csr_timer_irq.sv
`include "csr_defines.svh"

module csr_timer_irq (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               commit_en,
    input  csr_pkg::csr_addr_t commit_addr,
    input  csr_pkg::csr_word_t commit_data,
    input  csr_pkg::hw_irq_t   hardware_interrupt,
    input  logic               crmd_ie,
    output csr_pkg::csr_word_t ecfg,
    output csr_pkg::irq_vec_t  estat_is,
    output csr_pkg::csr_word_t tcfg,
    output csr_pkg::csr_word_t tval,
    output logic               cpu_interrupt,
    output logic               idle_over
);

    csr_pkg::irq_vec_t   lie_q;
    logic [1:0]          is_soft_q;
    csr_pkg::csr_word_t  tcfg_q;
    csr_pkg::csr_word_t  tval_q;
    csr_pkg::timer_val_t init_val;
    logic                set_timer;
    logic                time_out;
    logic                ti_pend;

    assign init_val = tcfg_q[`TCFG_INITVAL];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            lie_q     <= '0;
            is_soft_q <= '0;
            tcfg_q    <= '0;
            set_timer <= 1'b0;
        end else begin
            if (commit_en && commit_addr == `CSR_ECFG) begin
                lie_q <= commit_data[12:0] & `ECFG_LIE_MASK;
            end
            if (commit_en && commit_addr == `CSR_ESTAT) begin
                is_soft_q <= commit_data[`ESTAT_IS_SOFT];
            end
            if (commit_en && commit_addr == `CSR_TCFG) begin
                tcfg_q <= commit_data;
            end
            set_timer <= commit_en && commit_addr == `CSR_TCFG;
        end
    end

    // Down counter, reload on new config or periodic wrap
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval_q   <= '0;
            time_out <= 1'b0;
        end else if (set_timer || tval_q == '0) begin
            time_out <= 1'b0;
            if (set_timer || tcfg_q[`TCFG_PERIODIC]) begin
                tval_q <= {2'b00, init_val};
            end
        end else if (tcfg_q[`TCFG_EN]) begin
            tval_q   <= tval_q - 32'd1;
            time_out <= (tval_q == 32'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn || (commit_en && commit_addr == `CSR_TICLR)) begin
            ti_pend <= 1'b0;
        end else if (time_out) begin
            ti_pend <= 1'b1;
        end
    end

    always_comb begin
        estat_is                 = '0;
        estat_is[`ESTAT_IS_SOFT] = is_soft_q;
        estat_is[`ESTAT_IS_HARD] = hardware_interrupt;
        estat_is[`IRQ_TI_BIT]    = ti_pend;
    end

    assign ecfg          = {19'd0, lie_q};
    assign tcfg          = tcfg_q;
    assign tval          = tval_q;
    assign cpu_interrupt = crmd_ie && |(lie_q & estat_is);
    // Any pending line ends idle, enabled or not
    assign idle_over     = |estat_is;

endmodule

// File: verilog/csr_trap_regs.sv
`include "csr_defines.svh"

module csr_trap_regs (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               commit_en,
    input  csr_pkg::csr_addr_t commit_addr,
    input  csr_pkg::csr_word_t commit_data,
    input  logic               exception,
    input  logic               ertn,
    input  logic               tlb_exception,
    input  csr_pkg::expcode_t  expcode_in,
    input  logic               wen_expcode,
    input  csr_pkg::csr_word_t era_in,
    input  logic               wen_era,
    input  csr_pkg::csr_word_t badv_in,
    input  logic               wen_badv,
    output csr_pkg::csr_word_t crmd,
    output csr_pkg::csr_word_t prmd,
    output csr_pkg::ecode_t    ecode,
    output logic               esubcode,
    output csr_pkg::csr_word_t era,
    output csr_pkg::csr_word_t badv,
    output csr_pkg::csr_word_t eentry,
    output logic               crmd_ie
);

    csr_pkg::csr_word_t crmd_q;
    csr_pkg::csr_word_t prmd_q;
    csr_pkg::ecode_t    ecode_q;
    logic               esubcode_q;
    csr_pkg::csr_word_t era_q;
    csr_pkg::csr_word_t badv_q;
    csr_pkg::csr_word_t eentry_q;
    csr_pkg::plv_t      new_plv;

    assign new_plv = commit_data[`CRMD_PLV];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_q <= `CRMD_RESET;
        end else if (ertn) begin
            crmd_q[`CRMD_PLV] <= prmd_q[`PRMD_PPLV];
            crmd_q[`CRMD_IE]  <= prmd_q[`PRMD_PIE];
            // Back to paging after TLB refill
            if (ecode_q == `ECODE_TLBR) begin
                crmd_q[`CRMD_DA] <= 1'b0;
                crmd_q[`CRMD_PG] <= 1'b1;
            end
        end else if (exception) begin
            crmd_q[`CRMD_PLV] <= '0;
            crmd_q[`CRMD_IE]  <= 1'b0;
            if (tlb_exception) begin
                crmd_q[`CRMD_DA] <= 1'b1;
                crmd_q[`CRMD_PG] <= 1'b0;
            end
        end else if (commit_en && commit_addr == `CSR_CRMD) begin
            crmd_q[`CRMD_PLV]  <= new_plv;
            crmd_q[`CRMD_IE]   <= commit_data[`CRMD_IE];
            crmd_q[`CRMD_DATF] <= commit_data[`CRMD_DATF];
            crmd_q[`CRMD_DATM] <= commit_data[`CRMD_DATM];
            // Only a legal DA/PG pair is taken
            if (commit_data[`CRMD_DA] ^ commit_data[`CRMD_PG]) begin
                crmd_q[`CRMD_DA] <= commit_data[`CRMD_DA];
                crmd_q[`CRMD_PG] <= commit_data[`CRMD_PG];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_q     <= '0;
            ecode_q    <= '0;
            esubcode_q <= 1'b0;
            eentry_q   <= '0;
        end else begin
            if (exception) begin
                prmd_q[`PRMD_PPLV] <= crmd_q[`CRMD_PLV];
                prmd_q[`PRMD_PIE]  <= crmd_q[`CRMD_IE];
            end else if (commit_en && commit_addr == `CSR_PRMD) begin
                prmd_q[`PRMD_PPLV] <= commit_data[`PRMD_PPLV];
                prmd_q[`PRMD_PIE]  <= commit_data[`PRMD_PIE];
            end
            if (wen_expcode || exception) begin
                ecode_q    <= expcode_in[5:0];
                esubcode_q <= (expcode_in[5:0] == '0) ? 1'b0 : expcode_in[6];
            end
            if (commit_en && commit_addr == `CSR_EENTRY) begin
                eentry_q[31:`EENTRY_VA_LSB] <= commit_data[31:`EENTRY_VA_LSB];
            end
        end
    end

    // Hardware capture wins over software write
    always_ff @(posedge clk) begin
        if (wen_era) begin
            era_q <= era_in;
        end else if (commit_en && commit_addr == `CSR_ERA) begin
            era_q <= commit_data;
        end
        if (wen_badv) begin
            badv_q <= badv_in;
        end else if (commit_en && commit_addr == `CSR_BADV) begin
            badv_q <= commit_data;
        end
    end

    assign crmd     = crmd_q;
    assign prmd     = prmd_q;
    assign ecode    = ecode_q;
    assign esubcode = esubcode_q;
    assign era      = era_q;
    assign badv     = badv_q;
    assign eentry   = eentry_q;
    assign crmd_ie  = crmd_q[`CRMD_IE];

endmodule

// File: verilog/csr_write_stage.sv
`include "csr_defines.svh"

module csr_write_stage (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               wen_in,
    input  csr_pkg::csr_addr_t addr_in,
    input  csr_pkg::csr_word_t wdata_in,
    input  logic               d_idle,
    input  logic               flush,
    output logic               wen_csr,
    output logic               commit_en,
    output csr_pkg::csr_addr_t commit_addr,
    output csr_pkg::csr_word_t commit_data
);

    logic               pending;
    logic               phase;
    csr_pkg::csr_addr_t waddr_q;
    csr_pkg::csr_word_t wdata_q;

    // Idle-gated first step, commit follows one cycle later
    assign wen_csr     = pending && d_idle && !phase;
    assign commit_en   = phase;
    assign commit_addr = waddr_q;
    assign commit_data = wdata_q;

    always_ff @(posedge clk) begin
        if (!aresetn || flush) begin
            pending <= 1'b0;
            phase   <= 1'b0;
        end else begin
            phase <= wen_csr;
            if (wen_in) begin
                pending <= 1'b1;
            end else if (phase) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wen_in) begin
            waddr_q <= addr_in;
            wdata_q <= wdata_in;
        end
    end

endmodule

// File: verilog/csr_pkg.sv
package csr_pkg;

    // Data and address
    typedef logic [31:0] csr_word_t;
    typedef logic [13:0] csr_addr_t;

    // Mode and exception fields
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    // Subcode bit on top
    typedef logic [6:0]  expcode_t;

    // Interrupt lines
    typedef logic [12:0] irq_vec_t;
    typedef logic [7:0]  hw_irq_t;

    // Timer initial value field
    typedef logic [29:0] timer_val_t;

endpackage

// File: verilog/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// CSR numbers
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033
`define CSR_TID     14'h040
`define CSR_TCFG    14'h041
`define CSR_TVAL    14'h042
`define CSR_TICLR   14'h044

// Masks, codes and reset values
`define ECFG_LIE_MASK   13'h1bff
`define ECODE_TLBR      6'h3f
`define IRQ_TI_BIT      11
`define EENTRY_VA_LSB   6
// DA=1, DATF=1, DATM=1
`define CRMD_RESET      32'h0000_00a8

// Field positions
`define CRMD_PLV        1:0
`define CRMD_IE         2
`define CRMD_DA         3
`define CRMD_PG         4
`define CRMD_DATF       6:5
`define CRMD_DATM       8:7
`define PRMD_PPLV       1:0
`define PRMD_PIE        2
`define ESTAT_IS        12:0
`define ESTAT_IS_SOFT   1:0
`define ESTAT_IS_HARD   9:2
`define ESTAT_ECODE     21:16
`define ESTAT_ESUBCODE  22
`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITVAL    31:2

`endif
